// File: src.f
vmPkg.sv
vmApbRegs.sv
vmFetch.sv
vmOperandStage.sv
vmExecute.sv
vmTop.sv
tbClock.sv
vmTb_asserts.sv
vmTb.sv

// File: Makefile
# Verilator build and run of the test machine testbench

obj_dir/VvmTb: src.f $(shell cat src.f)
	verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
	  --top-module vmTb -f src.f -o VvmTb

run: obj_dir/VvmTb
	./obj_dir/VvmTb | tee sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// File: vmTb.sv
//----------------------------------------------------------------------
// Directed testbench of the test machine. Expects the default vmTop
// sizes: 12-bit data, 16 output entries, 64 code and local words.
//----------------------------------------------------------------------
`default_nettype none

module vmTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int DataWidth  = 12;
  localparam int OutDepth   = 16;
  localparam int CycleLimit = 20000;  // ~26 programs of under 300 cycles, with margin

  logic        clock, rstN;
  logic        psel, penable, pwrite;
  logic [11:0] paddr;
  logic [31:0] pwdata, prdata;
  logic        pready, pslverr;

  logic [31:0] codeWords[$];
  int          expected[$];
  integer      seed = 32'hb5fe_ab82;
  int          checks, errors, testErrors;
  int          cycles = 0;

  tbClock i_clock (.clock(clock), .rstN(rstN));

  vmTop #(
    .CodeDepth (64),
    .OutDepth  (OutDepth),
    .LocalDepth(64),
    .DataWidth (DataWidth)
  ) i_dut (
    .clock, .rstN, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr
  );

  // ----------------------------------------------------------------------
  // instruction encoding and value rules
  // ----------------------------------------------------------------------
  function automatic logic [8:0] imm(input int value);
    return {vmPkg::modeImmediate, 7'(value)};
  endfunction

  function automatic logic [8:0] dir(input int addr);
    return {vmPkg::modeDirect, 7'(addr)};
  endfunction

  function automatic logic [8:0] ind(input int addr);
    return {vmPkg::modeIndirect, 7'(addr)};
  endfunction

  function automatic logic [31:0] instr(input vmPkg::opcodeT op, input logic [8:0] target,
                                        input logic [8:0] src1, input logic [8:0] src2);
    return {op, target, src1, src2};
  endfunction

  function automatic logic [31:0] outInstr(input logic [8:0] src);
    return instr(vmPkg::opOut, imm(0), src, imm(0));
  endfunction

  // signed value modulo 2**DataWidth
  function automatic int wrap(input int value);
    logic signed [DataWidth-1:0] narrow;
    narrow = value[DataWidth-1:0];
    return narrow;
  endfunction

  // ----------------------------------------------------------------------
  // APB driver and checks
  // ----------------------------------------------------------------------
  task automatic apbTransfer(input logic write, input logic [11:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic err);
    @(posedge clock);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clock);
    #1;
    penable = 1'b1;
    #1;                                              // mid access phase
    rdata = prdata;
    err   = pslverr;
    @(posedge clock);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apbWrite(input logic [11:0] addr, input logic [31:0] data, output logic err);
    logic [31:0] unused;
    apbTransfer(1'b1, addr, data, unused, err);
  endtask

  task automatic apbRead(input logic [11:0] addr, output logic [31:0] data, output logic err);
    apbTransfer(1'b0, addr, 32'h0, data, err);
  endtask

  task automatic expectEqual(input string what, input int got, input int want);
    checks++;
    assert (got == want)
      else begin
        errors++;
        $display("Error at %0d ns: %s is %0d, expected %0d", $time, what, got, want);
      end
  endtask

  task automatic loadProgram();
    logic err;
    foreach (codeWords[i]) begin
      apbWrite(vmPkg::AddrCodeBase + 12'(4 * i), codeWords[i], err);
      expectEqual("code write error", err, 0);
    end
    apbWrite(vmPkg::AddrCtrl, codeWords.size(), err);
    expectEqual("start error", err, 0);
  endtask

  task automatic waitFinished();
    logic [31:0] data;
    logic        err;
    do begin
      apbRead(vmPkg::AddrStatus, data, err);
    end while (!data[31]);
  endtask

  // count saturates, so only the first OutDepth values are kept
  task automatic checkOutputs();
    logic [31:0] data;
    logic        err;
    int          count;
    count = expected.size() < OutDepth ? expected.size() : OutDepth;
    apbRead(vmPkg::AddrStatus, data, err);
    expectEqual("output count", int'(data[30:0]), count);
    for (int i = 0; i < count; i++) begin
      apbRead(vmPkg::AddrOutBase + 12'(4 * i), data, err);
      expectEqual($sformatf("output %0d", i), int'(data), wrap(expected[i]));
      expectEqual("output read error", err, 0);
    end
  endtask

  task automatic runAndCheck();
    loadProgram();
    waitFinished();
    checkOutputs();
  endtask

  task automatic reportTest(input string name);
    $display("test %s: %0d errors", name, errors - testErrors);
    testErrors = errors;
  endtask

  // ----------------------------------------------------------------------
  // directed tests
  // ----------------------------------------------------------------------
  task automatic testRegisters();
    logic [31:0] data;
    logic        err;
    apbRead(vmPkg::AddrStatus, data, err);
    expectEqual("status after reset", int'(data), 0);
    apbRead(12'h008, data, err);
    expectEqual("unmapped read error", err, 1);
    codeWords = {instr(vmPkg::opMov, dir(0), imm(50), imm(0)),
                 instr(vmPkg::opSubtract, dir(0), dir(0), imm(1)),
                 instr(vmPkg::opJNe, imm(-1), dir(0), imm(0))};  // 50 rounds
    expected = {};
    loadProgram();
    apbWrite(vmPkg::AddrCtrl, 32'd3, err);
    expectEqual("start while running error", err, 1);
    apbWrite(vmPkg::AddrCodeBase, 32'h0, err);
    expectEqual("code write while running error", err, 1);
    waitFinished();
    checkOutputs();
    apbRead(vmPkg::AddrOutBase, data, err);
    expectEqual("read past count error", err, 1);
  endtask

  task automatic testArithmetic();
    codeWords = {instr(vmPkg::opMov, dir(1), imm(5), imm(0)),
                 instr(vmPkg::opMov, dir(2), imm(3), imm(0)),
                 instr(vmPkg::opMov, ind(2), imm(-7), imm(0)),       // word 3 via word 2
                 instr(vmPkg::opAdd, dir(4), dir(1), dir(3)),        // reads word 3 at once
                 outInstr(dir(4)),
                 instr(vmPkg::opSubtract, dir(5), ind(2), imm(60)),
                 outInstr(dir(5)),
                 instr(vmPkg::opNot, dir(6), dir(4), imm(0)),
                 instr(vmPkg::opNot, dir(7), imm(0), imm(0)),
                 outInstr(dir(6)),
                 outInstr(dir(7)),
                 instr(vmPkg::opMov, {vmPkg::modeInvalid, 7'd1}, imm(20), imm(0)),
                 instr(vmPkg::opMov, imm(1), imm(20), imm(0)),        // no write either
                 instr(vmPkg::opMov, dir(8), dir(1), imm(0)),
                 outInstr(dir(8)),
                 outInstr(ind(2)),
                 outInstr({vmPkg::modeInvalid, 7'd5})};
    expected = {5 + -7, -7 - 60, 0, 1, 5, -7, 0};
    runAndCheck();
  endtask

  task automatic testShifts();
    codeWords = {instr(vmPkg::opMov, dir(10), imm(63), imm(0)),
                 instr(vmPkg::opShiftLeft, dir(10), imm(5), imm(0)),
                 outInstr(dir(10)),
                 instr(vmPkg::opShiftLeft, dir(10), imm(1), imm(0)),  // wraps negative
                 outInstr(dir(10)),
                 instr(vmPkg::opShiftRight, dir(10), imm(4), imm(0)),
                 outInstr(dir(10))};
    expected = {63 << 5, 63 << 6, (63 << 6) % (1 << DataWidth) >> 4};  // logical right
    runAndCheck();
  endtask

  task automatic testJumps();
    codeWords = {instr(vmPkg::opMov, dir(20), imm(3), imm(0)),
                 outInstr(dir(20)),                                   // 1
                 instr(vmPkg::opSubtract, dir(20), dir(20), imm(1)),
                 instr(vmPkg::opJGe, imm(-2), dir(20), imm(1)),       // back to 1
                 instr(vmPkg::opJNe, imm(5), dir(20), imm(0)),        // not taken
                 instr(vmPkg::opJmp, imm(3), imm(0), imm(0)),         // to 8
                 outInstr(imm(6)),                                    // 6
                 instr(vmPkg::opJmp, imm(3), imm(0), imm(0)),         // to 10
                 instr(vmPkg::opJNe, imm(-2), imm(1), imm(0)),        // back to 6
                 outInstr(imm(99)),
                 instr(vmPkg::opJFalse, imm(2), imm(5), imm(0)),      // not taken
                 outInstr(imm(7)),
                 instr(vmPkg::opJTrue, imm(2), imm(1), imm(0)),       // to 14
                 outInstr(imm(99)),
                 outInstr(imm(8))};
    expected = {3, 2, 1, 6, 7, 8};
    runAndCheck();
  endtask

  task automatic testHaltAndLimit();
    codeWords = {outInstr(imm(1)),
                 instr(vmPkg::opHalt, imm(0), imm(0), imm(0)),
                 outInstr(imm(2))};
    expected = {1};
    runAndCheck();
    codeWords = {instr(vmPkg::opMov, dir(30), imm(20), imm(0)),
                 outInstr(dir(30)),
                 instr(vmPkg::opSubtract, dir(30), dir(30), imm(1)),
                 instr(vmPkg::opJNe, imm(-2), dir(30), imm(0))};
    expected = {};
    for (int v = 20; v > 0; v--) begin
      expected.push_back(v);
    end
    runAndCheck();
  endtask

  task automatic testRandom();
    int            model[8];
    int            op, t, a, b;
    vmPkg::opcodeT code;
    for (int p = 0; p < 20; p++) begin
      codeWords = {};
      expected  = {};
      for (int i = 0; i < 8; i++) begin
        model[i] = $random(seed) % 64;               // fits a 7-bit immediate
        codeWords.push_back(instr(vmPkg::opMov, dir(40 + i), imm(model[i]), imm(0)));
      end
      for (int n = 0; n < 10; n++) begin
        op   = $unsigned($random(seed)) % 3;
        t    = $unsigned($random(seed)) % 8;
        a    = $unsigned($random(seed)) % 8;
        b    = $unsigned($random(seed)) % 8;
        code = op == 0 ? vmPkg::opAdd : op == 1 ? vmPkg::opSubtract : vmPkg::opMov;
        model[t] = wrap(op == 0 ? model[a] + model[b] : op == 1 ? model[a] - model[b]
                                                                : model[a]);
        codeWords.push_back(instr(code, dir(40 + t), dir(40 + a), dir(40 + b)));
      end
      for (int i = 0; i < 8; i++) begin
        codeWords.push_back(outInstr(dir(40 + i)));
        expected.push_back(model[i]);
      end
      runAndCheck();
    end
  endtask

  // ----------------------------------------------------------------------
  // run control
  // ----------------------------------------------------------------------
  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles == CycleLimit) begin
      $display("Timeout: the run did not end within %0d cycles", CycleLimit);
      $display("Checks failed");
      $finish;
    end
  end

  initial begin
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    checks     = 0;
    errors     = 0;
    testErrors = 0;
    @(posedge rstN);
    testRegisters();
    reportTest("registers");
    testArithmetic();
    reportTest("arithmetic");
    testShifts();
    reportTest("shifts");
    testJumps();
    reportTest("jumps");
    testHaltAndLimit();
    reportTest("halt and limit");
    testRandom();
    reportTest("random");
    errors += i_dut.i_asserts.failures;              // bound property failures
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vmTb_asserts.sv
//----------------------------------------------------------------------
// APB and finished-flag properties, bound into every vmTop instance.
// failures holds the number of property failures seen so far.
//----------------------------------------------------------------------
`default_nettype none

module vmTbAsserts (
  input logic clock,
  input logic rstN,
  input logic psel,
  input logic penable,
  input logic pready,
  input logic pslverr,
  input logic start,
  input logic finished
);
  timeunit 1ns;
  timeprecision 100ps;

  int failures = 0;

  readyHigh: assert property (@(posedge clock) disable iff (!rstN) pready)
    else begin
      failures++;
      $error("pready dropped low");
    end

  // error response only in the access phase
  errorInAccess: assert property (@(posedge clock) disable iff (!rstN)
    pslverr |-> psel && penable)
    else begin
      failures++;
      $error("pslverr raised outside the access phase");
    end

  finishedHeld: assert property (@(posedge clock) disable iff (!rstN)
    finished && !start |=> finished)
    else begin
      failures++;
      $error("finished dropped without a start");
    end

endmodule

bind vmTop vmTbAsserts i_asserts (
  .clock   (clock),
  .rstN    (rstN),
  .psel    (psel),
  .penable (penable),
  .pready  (pready),
  .pslverr (pslverr),
  .start   (start),
  .finished(finished)
);

`default_nettype wire

// File: tbClock.sv
//----------------------------------------------------------------------
// Testbench clock, 4 ns period. rstN is held low for 3 rising edges
// and released 1 ns after the third.
//----------------------------------------------------------------------
`default_nettype none

module tbClock (
  output logic clock,
  output logic rstN
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  initial begin
    rstN = 1'b0;
    repeat (3) @(posedge clock);
    #1 rstN = 1'b1;                                  // off the edge
  end

endmodule

`default_nettype wire

// File: vmTop.sv
//--------------------------------------------------------------------
// Test machine top level. Host access is APB only; see vmPkg for the
// address map.
//--------------------------------------------------------------------
`default_nettype none

module vmTop #(
  parameter int CodeDepth  = 64,
  parameter int OutDepth   = 16,
  parameter int LocalDepth = 64,
  parameter int DataWidth  = 12
) (
  input  logic        clock,
  input  logic        rstN,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [11:0] paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr
);

  // host side
  logic                             codeWrite, start;
  logic [$clog2(CodeDepth)-1:0]     codeAddr;
  logic [vmPkg::InstrWidth-1:0]     codeData;
  logic [vmPkg::PcWidth-1:0]        programLength;

  // pipeline
  logic                             fetchReady, fetchValid;
  logic [vmPkg::InstrWidth-1:0]     fetchInstr;
  logic [vmPkg::PcWidth-1:0]        fetchPc, opPc, jumpOffset, branchTarget;
  logic                             opValid, targetWritable, branchTaken;
  vmPkg::opcodeT                    opOpcode;
  logic [DataWidth-1:0]             src1Value, src2Value, targetValue;
  logic [vmPkg::FieldWidth-1:0]     targetAddr, wrAddr;
  logic                             wrEnable, outPush, finished;
  logic [DataWidth-1:0]             wrData, outData;

  vmApbRegs #(
    .CodeDepth(CodeDepth),
    .OutDepth (OutDepth),
    .DataWidth(DataWidth)
  ) i_apbRegs (.*);

  vmFetch #(
    .CodeDepth(CodeDepth)
  ) i_fetch (.*);

  vmOperandStage #(
    .LocalDepth(LocalDepth),
    .DataWidth (DataWidth)
  ) i_operandStage (.*);

  vmExecute #(
    .DataWidth(DataWidth)
  ) i_execute (.*);

endmodule

`default_nettype wire

// File: vmExecute.sv
//--------------------------------------------------------------------
// Execute stage, combinational on the operand register. Items are
// ignored while finished and in the cycle right after a start.
//--------------------------------------------------------------------
`default_nettype none

module vmExecute #(
  parameter int DataWidth = 12
) (
  input  logic                            clock,
  input  logic                            rstN,
  input  logic                            start,
  input  logic                            opValid,
  input  vmPkg::opcodeT                   opOpcode,
  input  logic [vmPkg::PcWidth-1:0]       opPc,
  input  logic [DataWidth-1:0]            src1Value,
  input  logic [DataWidth-1:0]            src2Value,
  input  logic [DataWidth-1:0]            targetValue,
  input  logic [vmPkg::FieldWidth-1:0]    targetAddr,
  input  logic                            targetWritable,
  input  logic [vmPkg::PcWidth-1:0]       jumpOffset,
  output logic                            wrEnable,
  output logic [vmPkg::FieldWidth-1:0]    wrAddr,
  output logic [DataWidth-1:0]            wrData,
  output logic                            branchTaken,
  output logic [vmPkg::PcWidth-1:0]       branchTarget,
  output logic                            outPush,
  output logic [DataWidth-1:0]            outData,
  output logic                            finished
);

  logic                 active, startLate, jumpCond;
  logic [DataWidth-1:0] result;

  assign active = opValid && !finished && !startLate;  // stale item after start

  always_comb begin
    result   = '0;
    jumpCond = 1'b0;
    case (opOpcode)
      vmPkg::opAdd:        result   = src1Value + src2Value;
      vmPkg::opSubtract:   result   = src1Value - src2Value;
      vmPkg::opMov:        result   = src1Value;
      vmPkg::opNot:        result   = DataWidth'(src1Value == '0);
      vmPkg::opShiftLeft:  result   = targetValue << src1Value;
      vmPkg::opShiftRight: result   = targetValue >> src1Value;
      vmPkg::opJmp:        jumpCond = 1'b1;
      vmPkg::opJEq:        jumpCond = src1Value == src2Value;
      vmPkg::opJNe:        jumpCond = src1Value != src2Value;
      vmPkg::opJLt:        jumpCond = $signed(src1Value) < $signed(src2Value);
      vmPkg::opJGe:        jumpCond = $signed(src1Value) >= $signed(src2Value);
      vmPkg::opJFalse:     jumpCond = src1Value == '0;
      vmPkg::opJTrue:      jumpCond = src1Value != '0;
      default:             result   = '0;      // nop, out, halt, undefined
    endcase
  end

  assign wrEnable     = active && vmPkg::writesTarget(opOpcode) && targetWritable;
  assign wrAddr       = targetAddr;
  assign wrData       = result;
  assign branchTaken  = active && jumpCond;
  assign branchTarget = opPc + jumpOffset;
  assign outPush      = active && opOpcode == vmPkg::opOut;
  assign outData      = src1Value;

  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      finished  <= 1'b0;
      startLate <= 1'b0;
    end else begin
      startLate <= start;
      if (start) begin
        finished <= 1'b0;
      end else if (active && opOpcode == vmPkg::opHalt) begin
        finished <= 1'b1;                            // held until next start
      end
    end
  end

endmodule

`default_nettype wire

// File: vmOperandStage.sv
//--------------------------------------------------------------------
// Operand stage with local memory. LocalDepth must be a power of two
// and DataWidth at least FieldWidth. A local write costs one bubble.
//--------------------------------------------------------------------
`default_nettype none

module vmOperandStage #(
  parameter int LocalDepth = 64,
  parameter int DataWidth  = 12
) (
  input  logic                            clock,
  input  logic                            rstN,
  input  logic                            fetchValid,
  input  logic [vmPkg::InstrWidth-1:0]    fetchInstr,
  input  logic [vmPkg::PcWidth-1:0]       fetchPc,
  input  logic                            branchTaken,
  input  logic                            wrEnable,
  input  logic [vmPkg::FieldWidth-1:0]    wrAddr,
  input  logic [DataWidth-1:0]            wrData,
  output logic                            fetchReady,
  output logic                            opValid,
  output vmPkg::opcodeT                   opOpcode,
  output logic [vmPkg::PcWidth-1:0]       opPc,
  output logic [DataWidth-1:0]            src1Value,
  output logic [DataWidth-1:0]            src2Value,
  output logic [DataWidth-1:0]            targetValue,
  output logic [vmPkg::FieldWidth-1:0]    targetAddr,
  output logic                            targetWritable,
  output logic [vmPkg::PcWidth-1:0]       jumpOffset
);

  localparam int LocalAddrW = $clog2(LocalDepth);
  localparam int FieldW     = vmPkg::FieldWidth;
  localparam int OperandW   = vmPkg::OperandWidth;

  logic [DataWidth-1:0] localMem [LocalDepth];
  logic [OperandW-1:0]  targetOp, src1Op, src2Op;
  logic [FieldW-1:0]    targetField, resolvedAddr;
  logic [DataWidth-1:0] targetPointer;
  vmPkg::opcodeT        opcode;
  vmPkg::modeT          targetMode;
  logic holdCycle, writable, accept;

  function automatic logic [DataWidth-1:0] readLocal(input logic [FieldW-1:0] addr);
    return localMem[addr[LocalAddrW-1:0]];
  endfunction

  // value of an operand by its mode
  function automatic logic [DataWidth-1:0] resolve(input logic [OperandW-1:0] operand);
    vmPkg::modeT          mode;
    logic [FieldW-1:0]    field;
    logic [DataWidth-1:0] pointer;
    mode    = vmPkg::modeT'(operand[OperandW-1:FieldW]);
    field   = operand[FieldW-1:0];
    pointer = readLocal(field);
    case (mode)
      vmPkg::modeImmediate: return DataWidth'(signed'(field));
      vmPkg::modeDirect:    return pointer;
      vmPkg::modeIndirect:  return readLocal(pointer[FieldW-1:0]);
      default:              return '0;
    endcase
  endfunction

  // ------------------------------------------------------------------
  // decode
  // ------------------------------------------------------------------
  assign opcode        = vmPkg::opcodeT'(fetchInstr[vmPkg::InstrWidth-1:vmPkg::OpcodeLsb]);
  assign targetOp      = fetchInstr[vmPkg::TargetLsb +: OperandW];
  assign src1Op        = fetchInstr[vmPkg::Src1Lsb +: OperandW];
  assign src2Op        = fetchInstr[OperandW-1:0];
  assign targetMode    = vmPkg::modeT'(targetOp[OperandW-1:FieldW]);
  assign targetField   = targetOp[FieldW-1:0];
  assign targetPointer = readLocal(targetField);
  assign resolvedAddr  = targetMode == vmPkg::modeIndirect ? targetPointer[FieldW-1:0]
                                                           : targetField;
  assign writable      = targetMode inside {vmPkg::modeDirect, vmPkg::modeIndirect};

  assign fetchReady = !holdCycle;
  assign accept     = fetchValid && fetchReady && !branchTaken;

  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      opValid   <= 1'b0;
      holdCycle <= 1'b0;
    end else begin
      opValid   <= accept;                           // bubble while holding
      holdCycle <= accept && writable && vmPkg::writesTarget(opcode);
    end
  end

  always_ff @(posedge clock) begin
    if (fetchReady) begin
      opOpcode       <= opcode;
      opPc           <= fetchPc;
      src1Value      <= resolve(src1Op);
      src2Value      <= resolve(src2Op);
      targetValue    <= resolve(targetOp);
      targetAddr     <= resolvedAddr;
      targetWritable <= writable;
      jumpOffset     <= vmPkg::PcWidth'(signed'(targetField));  // relative offset
    end
  end

  // ------------------------------------------------------------------
  // local memory, single write port from execute
  // ------------------------------------------------------------------
  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < LocalDepth; i++) begin
        localMem[i] <= '0;
      end
    end else if (wrEnable) begin
      localMem[wrAddr[LocalAddrW-1:0]] <= wrData;
    end
  end

endmodule

`default_nettype wire

// File: vmFetch.sv
//--------------------------------------------------------------------
// Fetch stage. One code word per cycle; once the pointer leaves the
// loaded program a single halt token is issued and fetch idles.
//--------------------------------------------------------------------
`default_nettype none

module vmFetch #(
  parameter int CodeDepth = 64
) (
  input  logic                             clock,
  input  logic                             rstN,
  input  logic                             codeWrite,
  input  logic [$clog2(CodeDepth)-1:0]     codeAddr,
  input  logic [vmPkg::InstrWidth-1:0]     codeData,
  input  logic                             start,
  input  logic [vmPkg::PcWidth-1:0]        programLength,
  input  logic                             fetchReady,
  input  logic                             branchTaken,
  input  logic [vmPkg::PcWidth-1:0]        branchTarget,
  output logic                             fetchValid,
  output logic [vmPkg::InstrWidth-1:0]     fetchInstr,
  output logic [vmPkg::PcWidth-1:0]        fetchPc
);

  localparam int CodeAddrW = $clog2(CodeDepth);
  localparam logic [vmPkg::InstrWidth-1:0] HaltWord =
    {vmPkg::opHalt, {(vmPkg::InstrWidth - vmPkg::OpcodeWidth){1'b0}}};

  typedef enum logic {stateIdle, stateRun} stateT;

  logic [vmPkg::InstrWidth-1:0] codeMem [CodeDepth];
  logic [vmPkg::PcWidth-1:0]    ip;
  stateT state;
  logic  advance, inRange;

  assign advance = !fetchValid || fetchReady;
  assign inRange = ip < programLength && ip < CodeDepth;  // negative targets wrap high

  always_ff @(posedge clock) begin
    if (codeWrite) begin
      codeMem[codeAddr] <= codeData;
    end
    if (advance) begin
      fetchInstr <= inRange ? codeMem[ip[CodeAddrW-1:0]] : HaltWord;
      fetchPc    <= ip;
    end
  end

  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      state      <= stateIdle;
      ip         <= '0;
      fetchValid <= 1'b0;
    end else if (start) begin
      state      <= stateRun;
      ip         <= '0;
      fetchValid <= 1'b0;
    end else if (branchTaken) begin
      state      <= stateRun;                        // resume even after the token
      ip         <= branchTarget;
      fetchValid <= 1'b0;                            // drop the wrong-path word
    end else if (advance) begin
      fetchValid <= state == stateRun;
      if (state == stateRun && !inRange) begin
        state <= stateIdle;                          // halt token goes out now
      end else if (state == stateRun) begin
        ip <= ip + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: vmApbRegs.sv
//--------------------------------------------------------------------
// APB slave of the test machine, no wait states. paddr[1:0] is not
// decoded. Code and output windows must fit below 0x1000.
//--------------------------------------------------------------------
`default_nettype none

module vmApbRegs #(
  parameter int CodeDepth = 64,
  parameter int OutDepth  = 16,
  parameter int DataWidth = 12
) (
  input  logic                           clock,
  input  logic                           rstN,
  input  logic                           psel,
  input  logic                           penable,
  input  logic                           pwrite,
  input  logic [11:0]                    paddr,
  input  logic [31:0]                    pwdata,
  output logic [31:0]                    prdata,
  output logic                           pready,
  output logic                           pslverr,
  output logic                           codeWrite,
  output logic [$clog2(CodeDepth)-1:0]   codeAddr,
  output logic [vmPkg::InstrWidth-1:0]   codeData,
  output logic                           start,
  output logic [vmPkg::PcWidth-1:0]      programLength,
  input  logic                           outPush,
  input  logic [DataWidth-1:0]           outData,
  input  logic                           finished
);

  localparam int CodeAddrW = $clog2(CodeDepth);
  localparam int OutAddrW  = $clog2(OutDepth);
  localparam int CountW    = $clog2(OutDepth + 1);

  logic                 running;
  logic [CountW-1:0]    outCount;
  logic [DataWidth-1:0] outMem [OutDepth];
  logic [DataWidth-1:0] outWord;
  logic [11:0]          codeOffset;
  logic [11:0]          outOffset;
  logic [OutAddrW-1:0]  outIndex;
  logic access, busy, startReq, outFull;
  logic isCtrl, isStatus, isCode, isOut;

  // ------------------------------------------------------------------
  // address decode
  // ------------------------------------------------------------------
  assign access     = psel && penable;
  assign busy       = running || start;              // program loaded or starting
  assign codeOffset = paddr - vmPkg::AddrCodeBase;
  assign outOffset  = paddr - vmPkg::AddrOutBase;
  assign outIndex   = outOffset[OutAddrW+1:2];
  assign isCtrl     = paddr == vmPkg::AddrCtrl;
  assign isStatus   = paddr == vmPkg::AddrStatus;
  assign isCode     = paddr >= vmPkg::AddrCodeBase && codeOffset < 4 * CodeDepth;
  assign isOut      = paddr >= vmPkg::AddrOutBase && outOffset < 4 * OutDepth;

  assign pready  = 1'b1;
  assign pslverr = access && (pwrite ? (!(isCtrl || isCode) || busy)
                                     : !(isStatus || (isOut && outIndex < outCount)));

  assign outWord = outMem[outIndex];
  assign prdata  = isStatus ? {finished, 31'(outCount)}
                            : {{(32 - DataWidth){outWord[DataWidth-1]}}, outWord};

  assign codeWrite = access && pwrite && isCode && !busy;
  assign codeAddr  = codeOffset[CodeAddrW+1:2];
  assign codeData  = pwdata;

  assign startReq = access && pwrite && isCtrl && !busy;
  assign outFull  = outCount == CountW'(OutDepth);

  // ------------------------------------------------------------------
  // control state
  // ------------------------------------------------------------------
  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      start    <= 1'b0;
      running  <= 1'b0;
      outCount <= '0;
    end else begin
      start <= startReq;                             // one cycle pulse
      if (start) begin
        running <= 1'b1;
      end else if (finished) begin
        running <= 1'b0;
      end
      if (start) begin
        outCount <= '0;
      end else if (outPush && !outFull) begin
        outCount <= outCount + 1'b1;                 // saturates at OutDepth
      end
    end
  end

  always_ff @(posedge clock) begin
    if (startReq) begin
      programLength <= pwdata[vmPkg::PcWidth-1:0];
    end
    if (outPush && !outFull) begin
      outMem[outCount[OutAddrW-1:0]] <= outData;     // dropped when full
    end
  end

endmodule

`default_nettype wire

// File: vmPkg.sv
//--------------------------------------------------------------------
// Shared types and constants of the test machine. A code word holds
// the opcode, target, source 1 and source 2 from the top bit down.
//--------------------------------------------------------------------
`default_nettype none

package vmPkg;

  localparam int InstrWidth   = 32;
  localparam int OpcodeWidth  = 5;
  localparam int ModeWidth    = 2;
  localparam int FieldWidth   = 7;
  localparam int OperandWidth = ModeWidth + FieldWidth;  // mode then field
  localparam int PcWidth      = 12;                      // wide enough for any code map

  localparam int OpcodeLsb = InstrWidth - OpcodeWidth;
  localparam int TargetLsb = 2 * OperandWidth;
  localparam int Src1Lsb   = OperandWidth;

  typedef enum logic [OpcodeWidth-1:0] {
    opNop, opAdd, opSubtract, opMov, opNot, opShiftLeft, opShiftRight, opOut,
    opJmp, opJEq, opJNe, opJLt, opJGe, opJFalse, opJTrue, opHalt
  } opcodeT;  // codes above opHalt act as nop

  typedef enum logic [ModeWidth-1:0] {
    modeImmediate, modeDirect, modeIndirect, modeInvalid
  } modeT;

  // APB byte addresses
  localparam logic [11:0] AddrCtrl     = 12'h000;  // write program length to start
  localparam logic [11:0] AddrStatus   = 12'h004;  // finished in bit 31, count below
  localparam logic [11:0] AddrOutBase  = 12'h100;
  localparam logic [11:0] AddrCodeBase = 12'h200;

  // opcodes whose result lands in the target operand
  function automatic logic writesTarget(input opcodeT opcode);
    return opcode inside {opAdd, opSubtract, opMov, opNot, opShiftLeft, opShiftRight};
  endfunction

endpackage

`default_nettype wire
